//--- hw/host_link_pkg.sv
// shared constants; CLKS_PER_BIT must be at least 2, and the write code must match the bus master
package host_link_pkg;

	// serial timing
	// clocks per bit, kept tiny so simulation stays short
	localparam int unsigned CLKS_PER_BIT = 8;
	// width of the per-bit timers in both UARTs
	localparam int unsigned BIT_TIMER_W = $clog2(CLKS_PER_BIT);
	// last tick of a full bit
	localparam logic [BIT_TIMER_W-1:0] BIT_LAST = BIT_TIMER_W'(CLKS_PER_BIT - 1);
	// last tick of a half bit, used to find the middle of the start bit
	localparam logic [BIT_TIMER_W-1:0] HALF_BIT_LAST = BIT_TIMER_W'(CLKS_PER_BIT / 2 - 1);

	// frame markers
	// 'L' opens a request
	localparam logic [7:0] CHAR_L = 8'h4C;
	// 'S' opens a response
	localparam logic [7:0] CHAR_S = 8'h53;

	// hex digit bounds, upper case only
	localparam logic [7:0] CHAR_0 = 8'h30;
	localparam logic [7:0] CHAR_A = 8'h41;
	localparam logic [7:0] CHAR_F = 8'h46;
	// nibble 10..15 plus this gives 'A'..'F'
	localparam logic [7:0] HEX_LETTER_OFFSET = 8'h37;

	// field widths
	// command, address, data and status
	localparam int unsigned WORD_W = 32;
	// word count, seven hex digits on the wire
	localparam int unsigned COUNT_W = 28;
	// hex digits per 32-bit word
	localparam int unsigned WORD_DIGITS = WORD_W / 4;

	// low 16 bits of the command that mark a write
	localparam logic [15:0] COMMAND_WRITE = 16'h0001;

endpackage

//--- hw/uart_rx.sv
// 8N1 receiver; no parity, a byte with a bad stop bit is dropped silently, no error flag
module uart_rx (
	input  logic       clk,
	input  logic       rst,
	input  logic       rx_line,
	output logic [7:0] rx_byte,
	output logic       rx_strobe
);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t state;
	// two flop synchroniser, idles high like the line
	logic [1:0] rx_sync;
	logic       rx_bit;
	logic [host_link_pkg::BIT_TIMER_W-1:0] bit_timer;
	// which data bit comes next, lsb first
	logic [2:0] bit_index;
	logic [7:0] shift_reg;

	always_ff @(posedge clk) begin
		if (rst) begin
			rx_sync <= 2'b11;
		end else begin
			rx_sync <= {rx_sync[0], rx_line};
		end
	end

	assign rx_bit = rx_sync[1];

	always_ff @(posedge clk) begin
		if (rst) begin
			state     <= RX_IDLE;
			bit_timer <= '0;
			bit_index <= '0;
			rx_strobe <= 1'b0;
		end else begin
			// strobe is a single cycle pulse
			rx_strobe <= 1'b0;
			case (state)
				RX_IDLE: begin
					bit_timer <= '0;
					bit_index <= '0;
					// falling edge starts a frame
					if (!rx_bit) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					if (bit_timer == host_link_pkg::HALF_BIT_LAST) begin
						bit_timer <= '0;
						// line back high at mid start bit means a glitch
						state <= rx_bit ? RX_IDLE : RX_DATA;
					end else begin
						bit_timer <= bit_timer + 1'b1;
					end
				end
				RX_DATA: begin
					if (bit_timer == host_link_pkg::BIT_LAST) begin
						bit_timer <= '0;
						// sample at mid bit, shift in from the top
						shift_reg <= {rx_bit, shift_reg[7:1]};
						bit_index <= bit_index + 1'b1;
						if (bit_index == 3'd7) begin
							state <= RX_STOP;
						end
					end else begin
						bit_timer <= bit_timer + 1'b1;
					end
				end
				RX_STOP: begin
					if (bit_timer == host_link_pkg::BIT_LAST) begin
						state <= RX_IDLE;
						// only a clean stop bit hands the byte on
						if (rx_bit) begin
							rx_byte   <= shift_reg;
							rx_strobe <= 1'b1;
						end
					end else begin
						bit_timer <= bit_timer + 1'b1;
					end
				end
				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

endmodule

//--- hw/uart_tx.sv
// 8N1 transmitter; one byte in flight, ready stays low through the whole frame incl. stop bit
module uart_tx (
	input  logic       clk,
	input  logic       rst,
	input  logic [7:0] tx_byte,
	input  logic       tx_valid,
	output logic       tx_ready,
	output logic       tx_line
);

	// high from the transfer until the stop bit has finished
	logic       busy;
	// data bits then the stop bit, start bit goes straight to the line
	logic [8:0] frame;
	// bits still to put on the line after the current one
	logic [3:0] bits_left;
	logic [host_link_pkg::BIT_TIMER_W-1:0] bit_timer;

	assign tx_ready = !busy;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy      <= 1'b0;
			bits_left <= '0;
			bit_timer <= '0;
			tx_line   <= 1'b1;
		end else if (!busy) begin
			bit_timer <= '0;
			tx_line   <= 1'b1;
			if (tx_valid) begin
				// start bit in the cycle after the transfer
				busy      <= 1'b1;
				tx_line   <= 1'b0;
				frame     <= {1'b1, tx_byte};
				bits_left <= 4'd9;
			end
		end else begin
			if (bit_timer == host_link_pkg::BIT_LAST) begin
				bit_timer <= '0;
				if (bits_left == 4'd0) begin
					// stop bit done, line is already high
					busy <= 1'b0;
				end else begin
					tx_line   <= frame[0];
					frame     <= {1'b1, frame[8:1]};
					bits_left <= bits_left - 1'b1;
				end
			end else begin
				bit_timer <= bit_timer + 1'b1;
			end
		end
	end

endmodule

//--- hw/hex_request_parser.sv
// upper-case hex only; holds one word plus one shadow group, a third group while held aborts
module hex_request_parser (
	input  logic                               clk,
	input  logic                               rst,
	input  logic [7:0]                         rx_byte,
	input  logic                               rx_strobe,
	output logic                               req_valid,
	output logic [host_link_pkg::WORD_W-1:0]  req_command,
	output logic [host_link_pkg::WORD_W-1:0]  req_address,
	output logic [host_link_pkg::WORD_W-1:0]  req_data,
	output logic [host_link_pkg::COUNT_W-1:0] req_count,
	input  logic                               req_ready
);

	typedef enum logic [2:0] {
		ST_HUNT,
		ST_COUNT,
		ST_COMMAND,
		ST_ADDRESS,
		ST_DATA
	} parse_state_t;

	parse_state_t state;
	logic [2:0] nibble_cnt;
	// count field, then the remaining count of a write
	logic [host_link_pkg::COUNT_W-1:0] count_left;
	logic [host_link_pkg::WORD_W-1:0]  cmd_shift;
	logic [host_link_pkg::WORD_W-1:0]  addr_shift;
	logic [host_link_pkg::WORD_W-1:0]  data_shift;
	// completed group waiting behind the held word
	logic                              pending;
	logic [host_link_pkg::WORD_W-1:0]  pending_data;
	logic [host_link_pkg::COUNT_W-1:0] pending_count;

	logic       is_digit;
	logic       is_letter;
	logic       is_hex;
	logic [7:0] nibble_byte;
	logic [3:0] nibble;
	logic       is_write;
	logic [host_link_pkg::WORD_W-1:0] group_word;
	logic take;
	logic group_done;
	logic load_pending;
	logic load_group;
	logic store_group;
	logic overrun;

	// character classification
	assign is_digit  = (rx_byte >= host_link_pkg::CHAR_0) &&
		(rx_byte <= host_link_pkg::CHAR_0 + 8'd9);
	assign is_letter = (rx_byte >= host_link_pkg::CHAR_A) &&
		(rx_byte <= host_link_pkg::CHAR_F);
	assign is_hex    = is_digit || is_letter;
	assign nibble_byte = is_letter ? rx_byte - host_link_pkg::HEX_LETTER_OFFSET :
		rx_byte - host_link_pkg::CHAR_0;
	assign nibble = nibble_byte[3:0];

	assign is_write   = (cmd_shift[15:0] == host_link_pkg::COMMAND_WRITE);
	assign group_word = {data_shift[host_link_pkg::WORD_W-5:0], nibble};

	// handover decisions
	assign take         = req_valid && req_ready;
	assign group_done   = rx_strobe && is_hex && (state == ST_DATA) && (nibble_cnt == 3'd7);
	assign load_pending = take && pending;
	// output slot free, either empty or emptied this cycle with nothing queued
	assign load_group   = group_done && (!req_valid || (take && !pending));
	assign store_group  = group_done && !load_group && (!pending || take);
	assign overrun      = group_done && !load_group && !store_group;

	always_ff @(posedge clk) begin
		if (rst) begin
			state      <= ST_HUNT;
			nibble_cnt <= '0;
			count_left <= '0;
			req_valid  <= 1'b0;
			pending    <= 1'b0;
		end else begin
			req_valid <= load_group || load_pending || (req_valid && !take);
			pending   <= store_group || (pending && !take);

			if (rx_strobe) begin
				if (state != ST_HUNT && !is_hex) begin
					// bad character kills the frame
					state <= ST_HUNT;
				end else begin
					case (state)
						ST_HUNT: begin
							nibble_cnt <= '0;
							if (rx_byte == host_link_pkg::CHAR_L) begin
								state <= ST_COUNT;
							end
						end
						ST_COUNT: begin
							count_left <= {count_left[host_link_pkg::COUNT_W-5:0], nibble};
							if (nibble_cnt == 3'd6) begin
								nibble_cnt <= '0;
								state      <= ST_COMMAND;
							end else begin
								nibble_cnt <= nibble_cnt + 1'b1;
							end
						end
						ST_COMMAND: begin
							// 3 bit counter wraps to 0 after the eighth digit
							nibble_cnt <= nibble_cnt + 1'b1;
							if (nibble_cnt == 3'd7) begin
								state <= ST_ADDRESS;
							end
						end
						ST_ADDRESS: begin
							nibble_cnt <= nibble_cnt + 1'b1;
							if (nibble_cnt == 3'd7) begin
								state <= ST_DATA;
							end
						end
						ST_DATA: begin
							nibble_cnt <= nibble_cnt + 1'b1;
							if (group_done) begin
								if (overrun) begin
									state <= ST_HUNT;
								end else if (is_write && count_left != '0) begin
									// another data group follows
									count_left <= count_left - 1'b1;
								end else begin
									state <= ST_HUNT;
								end
							end
						end
						default: begin
							state <= ST_HUNT;
						end
					endcase
				end
			end
		end
	end

	// field shifters and the presented word
	always_ff @(posedge clk) begin
		if (rx_strobe && is_hex && state == ST_COMMAND) begin
			cmd_shift <= {cmd_shift[host_link_pkg::WORD_W-5:0], nibble};
		end
		if (rx_strobe && is_hex && state == ST_ADDRESS) begin
			addr_shift <= {addr_shift[host_link_pkg::WORD_W-5:0], nibble};
		end
		if (rx_strobe && is_hex && state == ST_DATA) begin
			data_shift <= group_word;
		end
		// command and address stay put until the next frame's command field
		if (load_group || load_pending) begin
			req_command <= cmd_shift;
			req_address <= addr_shift;
		end
		if (load_group) begin
			req_data  <= group_word;
			req_count <= count_left;
		end else if (load_pending) begin
			req_data  <= pending_data;
			req_count <= pending_count;
		end
		if (store_group) begin
			pending_data  <= group_word;
			pending_count <= count_left;
		end
	end

endmodule

//--- hw/hex_response_writer.sv
// emits S plus upper-case hex, msb nibble first; rsp_count is taken from the first word only
module hex_response_writer (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               rsp_valid,
	output logic                               rsp_ready,
	input  logic [host_link_pkg::WORD_W-1:0]  rsp_status,
	input  logic [host_link_pkg::WORD_W-1:0]  rsp_address,
	input  logic [host_link_pkg::WORD_W-1:0]  rsp_data,
	input  logic [host_link_pkg::COUNT_W-1:0] rsp_count,
	output logic [7:0]                         tx_byte,
	output logic                               tx_valid,
	input  logic                               tx_ready
);

	typedef enum logic [1:0] {
		W_IDLE,
		W_SEND,
		W_NEXT
	} write_state_t;

	write_state_t state;
	// status, address, data; the next digit always sits in the top nibble
	logic [3*host_link_pkg::WORD_W-1:0] hdr_shift;
	// digits of the current group not yet put on tx_byte
	logic [4:0] digits_left;
	// extra data words still to accept
	logic [host_link_pkg::COUNT_W-1:0] count_left;
	logic slot_free;
	logic rsp_take;

	function automatic logic [7:0] hex_char(input logic [3:0] value);
		logic [7:0] wide;
		wide = {4'h0, value};
		if (value < 4'd10) begin
			return host_link_pkg::CHAR_0 + wide;
		end
		return host_link_pkg::HEX_LETTER_OFFSET + wide;
	endfunction

	// tx_byte may be replaced when empty or taken this cycle
	assign slot_free = !tx_valid || tx_ready;
	assign rsp_take  = rsp_valid && rsp_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			state       <= W_IDLE;
			digits_left <= '0;
			count_left  <= '0;
			tx_valid    <= 1'b0;
			rsp_ready   <= 1'b0;
		end else begin
			case (state)
				W_IDLE: begin
					rsp_ready <= 1'b1;
					if (rsp_take) begin
						// header goes out as one 24 digit run after the marker
						hdr_shift   <= {rsp_status, rsp_address, rsp_data};
						count_left  <= rsp_count;
						digits_left <= 5'(3 * host_link_pkg::WORD_DIGITS);
						tx_byte     <= host_link_pkg::CHAR_S;
						tx_valid    <= 1'b1;
						rsp_ready   <= 1'b0;
						state       <= W_SEND;
					end
				end
				W_SEND: begin
					if (slot_free) begin
						if (digits_left != 5'd0) begin
							tx_byte     <= hex_char(hdr_shift[3*host_link_pkg::WORD_W-1 -: 4]);
							tx_valid    <= 1'b1;
							hdr_shift   <= hdr_shift << 4;
							digits_left <= digits_left - 1'b1;
						end else begin
							// last character handed over
							tx_valid  <= 1'b0;
							rsp_ready <= 1'b1;
							state     <= (count_left != '0) ? W_NEXT : W_IDLE;
						end
					end
				end
				W_NEXT: begin
					if (rsp_take) begin
						// only the data of follow-on words is sent
						hdr_shift[3*host_link_pkg::WORD_W-1 -: host_link_pkg::WORD_W] <= rsp_data;
						digits_left <= 5'(host_link_pkg::WORD_DIGITS);
						count_left  <= count_left - 1'b1;
						rsp_ready   <= 1'b0;
						state       <= W_SEND;
					end
				end
				default: begin
					state <= W_IDLE;
				end
			endcase
		end
	end

endmodule

//--- hw/uart_host_port.sv
// host port top; bus master is external, both serial lines idle high, no flow control
module uart_host_port (
	input  logic                               clk,
	input  logic                               rst,
	// serial lines
	input  logic                               rx_line,
	output logic                               tx_line,
	// request side, toward the bus master
	output logic                               req_valid,
	input  logic                               req_ready,
	output logic [host_link_pkg::WORD_W-1:0]  req_command,
	output logic [host_link_pkg::WORD_W-1:0]  req_address,
	output logic [host_link_pkg::WORD_W-1:0]  req_data,
	output logic [host_link_pkg::COUNT_W-1:0] req_count,
	// response side, from the bus master
	input  logic                               rsp_valid,
	output logic                               rsp_ready,
	input  logic [host_link_pkg::WORD_W-1:0]  rsp_status,
	input  logic [host_link_pkg::WORD_W-1:0]  rsp_address,
	input  logic [host_link_pkg::WORD_W-1:0]  rsp_data,
	input  logic [host_link_pkg::COUNT_W-1:0] rsp_count
);

	// receive path
	logic [7:0] rx_byte;
	logic       rx_strobe;
	// transmit path
	logic [7:0] tx_byte;
	logic       tx_valid;
	logic       tx_ready;

	uart_rx u_uart_rx (
		.clk       (clk),
		.rst       (rst),
		.rx_line   (rx_line),
		.rx_byte   (rx_byte),
		.rx_strobe (rx_strobe)
	);

	// input handler
	hex_request_parser u_parser (
		.clk         (clk),
		.rst         (rst),
		.rx_byte     (rx_byte),
		.rx_strobe   (rx_strobe),
		.req_valid   (req_valid),
		.req_command (req_command),
		.req_address (req_address),
		.req_data    (req_data),
		.req_count   (req_count),
		.req_ready   (req_ready)
	);

	// output handler
	hex_response_writer u_writer (
		.clk         (clk),
		.rst         (rst),
		.rsp_valid   (rsp_valid),
		.rsp_ready   (rsp_ready),
		.rsp_status  (rsp_status),
		.rsp_address (rsp_address),
		.rsp_data    (rsp_data),
		.rsp_count   (rsp_count),
		.tx_byte     (tx_byte),
		.tx_valid    (tx_valid),
		.tx_ready    (tx_ready)
	);

	uart_tx u_uart_tx (
		.clk      (clk),
		.rst      (rst),
		.tx_byte  (tx_byte),
		.tx_valid (tx_valid),
		.tx_ready (tx_ready),
		.tx_line  (tx_line)
	);

endmodule

//--- bench/uart_host_port_checker.sv
// bound into uart_host_port by port names; needs the internal tx_byte, tx_valid and tx_ready wires
module uart_host_port_checker (
	input logic                               clk,
	input logic                               rst,
	input logic                               req_valid,
	input logic                               req_ready,
	input logic [host_link_pkg::WORD_W-1:0]  req_command,
	input logic [host_link_pkg::WORD_W-1:0]  req_address,
	input logic [host_link_pkg::WORD_W-1:0]  req_data,
	input logic [host_link_pkg::COUNT_W-1:0] req_count,
	input logic                               rsp_valid,
	input logic                               rsp_ready,
	input logic [host_link_pkg::WORD_W-1:0]  rsp_status,
	input logic [host_link_pkg::WORD_W-1:0]  rsp_address,
	input logic [host_link_pkg::WORD_W-1:0]  rsp_data,
	input logic [host_link_pkg::COUNT_W-1:0] rsp_count,
	input logic [7:0]                         tx_byte,
	input logic                               tx_valid,
	input logic                               tx_ready,
	input logic                               tx_line
);

	// failed assertions so far, read by the testbench at the end
	int failures = 0;

	// request word held until taken
	a_req_hold: assert property (@(posedge clk) disable iff (rst)
		req_valid && !req_ready |=> req_valid &&
		$stable({req_command, req_address, req_data, req_count}))
		else begin
			failures = failures + 1;
			$error("request word changed or dropped while waiting");
		end

	// response word from the bus master side
	a_rsp_hold: assert property (@(posedge clk) disable iff (rst)
		rsp_valid && !rsp_ready |=> rsp_valid &&
		$stable({rsp_status, rsp_address, rsp_data, rsp_count}))
		else begin
			failures = failures + 1;
			$error("response word changed or dropped while waiting");
		end

	// writer to transmitter link
	a_tx_hold: assert property (@(posedge clk) disable iff (rst)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_byte))
		else begin
			failures = failures + 1;
			$error("tx_byte changed or dropped while waiting");
		end

	// no valid and no ready straight out of reset
	a_reset_quiet: assert property (@(posedge clk)
		rst |=> !req_valid && !tx_valid && !rsp_ready)
		else begin
			failures = failures + 1;
			$error("handshake active after reset");
		end

	// idle transmitter keeps the line high
	a_tx_idle: assert property (@(posedge clk) disable iff (rst)
		tx_ready |-> tx_line)
		else begin
			failures = failures + 1;
			$error("tx_line low while transmitter idle");
		end

endmodule

bind uart_host_port uart_host_port_checker u_checker (.*);

//--- bench/uart_host_port_tb.sv
// needs --timing; the bus master model stalls only the first word of a test and for less than one group time
module uart_host_port_tb;

	localparam int NUM_TESTS = 4;
	localparam int BIT_CLKS = int'(host_link_pkg::CLKS_PER_BIT);

	logic clk = 1'b0;
	logic rst;
	logic rx_line;
	logic tx_line;
	logic req_valid;
	logic req_ready;
	logic [host_link_pkg::WORD_W-1:0]  req_command;
	logic [host_link_pkg::WORD_W-1:0]  req_address;
	logic [host_link_pkg::WORD_W-1:0]  req_data;
	logic [host_link_pkg::COUNT_W-1:0] req_count;
	logic rsp_valid;
	logic rsp_ready;
	logic [host_link_pkg::WORD_W-1:0]  rsp_status;
	logic [host_link_pkg::WORD_W-1:0]  rsp_address;
	logic [host_link_pkg::WORD_W-1:0]  rsp_data;
	logic [host_link_pkg::COUNT_W-1:0] rsp_count;

	// request half of the stimulus table
	string       t_name[NUM_TESTS];
	string       t_prefix[NUM_TESTS];
	logic [27:0] t_count[NUM_TESTS];
	logic [31:0] t_cmd[NUM_TESTS];
	logic [31:0] t_addr[NUM_TESTS];
	logic [31:0] t_data[NUM_TESTS][3];
	// upper bound of the random req_ready stall
	// zero for no stall
	int          t_stall_max[NUM_TESTS];
	// response half
	logic [31:0] r_status[NUM_TESTS];
	logic [31:0] r_addr[NUM_TESTS];
	logic [31:0] r_data[NUM_TESTS];
	logic [27:0] r_count[NUM_TESTS];
	logic [31:0] r_extra[NUM_TESTS][2];

	// characters for rx_line and the expected and received tx characters
	logic [7:0]  send_q[$];
	logic [7:0]  exp_chars[$];
	logic [7:0]  got_chars[$];
	// expected request words of the current test
	logic [31:0] exp_data[$];
	logic [27:0] exp_count[$];

	int seed = 32'h4894_052a;
	int errors = 0;
	int checks = 0;
	int transfers = 0;
	int stop_errors = 0;
	int cycles = 0;
	int cycle_limit = 0;

	uart_host_port uut (.*);

	always #4 clk = ~clk;

	// watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: the DUT did not finish within %0d cycles", cycle_limit);
			$display("TEST FAILED");
			$finish;
		end
	end

	// count request transfers half a cycle before the edge that takes them
	always @(negedge clk) begin
		if (!rst && req_valid && req_ready) begin
			transfers <= transfers + 1;
		end
	end

	// decode tx_line at mid bit on falling edges
	initial begin
		logic [7:0] ch;
		forever begin
			@(negedge clk);
			if (tx_line === 1'b0) begin
				repeat (BIT_CLKS / 2) @(negedge clk);
				for (int i = 0; i < 8; i++) begin
					repeat (BIT_CLKS) @(negedge clk);
					ch[i] = tx_line;
				end
				repeat (BIT_CLKS) @(negedge clk);
				if (tx_line !== 1'b1) begin
					stop_errors = stop_errors + 1;
				end
				got_chars.push_back(ch);
			end
		end
	end

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks = checks + 1;
		if (expected !== actual) begin
			errors = errors + 1;
			$display("Fail %s expected 0x%08h got 0x%08h", name, expected, actual);
		end
	endtask

	task automatic set_request(input int t, input string nm, input string pre,
		input logic [27:0] cnt, input logic [31:0] cmd, input logic [31:0] addr,
		input logic [31:0] d0, input logic [31:0] d1, input logic [31:0] d2, input int stall);
		t_name[t] = nm;
		t_prefix[t] = pre;
		t_count[t] = cnt;
		t_cmd[t] = cmd;
		t_addr[t] = addr;
		t_data[t][0] = d0;
		t_data[t][1] = d1;
		t_data[t][2] = d2;
		t_stall_max[t] = stall;
	endtask

	task automatic set_response(input int t, input logic [31:0] st, input logic [31:0] ad,
		input logic [31:0] dt, input logic [27:0] cnt, input logic [31:0] x0,
		input logic [31:0] x1);
		r_status[t] = st;
		r_addr[t] = ad;
		r_data[t] = dt;
		r_count[t] = cnt;
		r_extra[t][0] = x0;
		r_extra[t][1] = x1;
	endtask

	// upper-case hex digit of one nibble
	function automatic logic [7:0] hex_digit(input logic [3:0] n);
		if (n < 4'd10) begin
			return host_link_pkg::CHAR_0 + {4'h0, n};
		end
		return host_link_pkg::CHAR_A + {4'h0, n} - 8'd10;
	endfunction

	// digits go msb first into the rx queue or the expected tx queue
	task automatic push_hex(input logic [31:0] value, input int digits, input bit to_line);
		logic [7:0] ch;
		for (int i = digits - 1; i >= 0; i--) begin
			ch = hex_digit(value[4*i +: 4]);
			if (to_line) begin
				send_q.push_back(ch);
			end else begin
				exp_chars.push_back(ch);
			end
		end
	endtask

	// request characters and the words they must yield
	task automatic build_frame(input int t);
		string pre;
		int groups;
		pre = t_prefix[t];
		send_q.delete();
		exp_data.delete();
		exp_count.delete();
		for (int i = 0; i < pre.len(); i++) begin
			send_q.push_back(pre[i]);
		end
		send_q.push_back(host_link_pkg::CHAR_L);
		push_hex({4'h0, t_count[t]}, 7, 1'b1);
		push_hex(t_cmd[t], 8, 1'b1);
		push_hex(t_addr[t], 8, 1'b1);
		// a write carries count more groups than a read
		groups = (t_cmd[t][15:0] == host_link_pkg::COMMAND_WRITE) ? int'(t_count[t]) + 1 : 1;
		for (int g = 0; g < groups; g++) begin
			push_hex(t_data[t][g], 8, 1'b1);
			exp_data.push_back(t_data[t][g]);
			exp_count.push_back(t_count[t] - 28'(g));
		end
	endtask

	// expected S frame with the header digits and the extra data words
	task automatic build_response(input int t);
		exp_chars.delete();
		exp_chars.push_back(host_link_pkg::CHAR_S);
		push_hex(r_status[t], 8, 1'b0);
		push_hex(r_addr[t], 8, 1'b0);
		push_hex(r_data[t], 8, 1'b0);
		for (int w = 0; w < int'(r_count[t]); w++) begin
			push_hex(r_extra[t][w], 8, 1'b0);
		end
	endtask

	task automatic drive_bit(input logic value);
		rx_line <= value;
		repeat (BIT_CLKS) @(posedge clk);
	endtask

	// send_q goes out as 8N1 with a random idle gap after each character
	task automatic drive_frame();
		logic [7:0] b;
		int gap;
		while (send_q.size() > 0) begin
			b = send_q.pop_front();
			drive_bit(1'b0);
			for (int i = 0; i < 8; i++) begin
				drive_bit(b[i]);
			end
			drive_bit(1'b1);
			gap = {$random(seed)} % 16;
			repeat (gap) @(posedge clk);
		end
	endtask

	task automatic take_words(input int t, input int stall);
		logic [31:0] held_cmd;
		logic [31:0] held_addr;
		logic [31:0] held_data;
		logic [27:0] held_count;
		for (int k = 0; k < exp_data.size(); k++) begin
			do @(negedge clk); while (!req_valid);
			if (k == 0 && stall > 0) begin
				held_cmd = req_command;
				held_addr = req_address;
				held_data = req_data;
				held_count = req_count;
				// word must sit still while ready is low
				repeat (stall) begin
					@(negedge clk);
					check_value("req_valid", 32'd1, 32'(req_valid));
					check_value("req_command", held_cmd, req_command);
					check_value("req_address", held_addr, req_address);
					check_value("req_data", held_data, req_data);
					check_value("req_count", {4'h0, held_count}, {4'h0, req_count});
				end
				@(posedge clk);
				req_ready <= 1'b1;
				@(negedge clk);
			end
			check_value("req_command", t_cmd[t], req_command);
			check_value("req_address", t_addr[t], req_address);
			check_value("req_data", exp_data[k], req_data);
			check_value("req_count", {4'h0, exp_count[k]}, {4'h0, req_count});
		end
	endtask

	// the first word carries the header and later words change only rsp_data
	task automatic send_response(input int t);
		rsp_status <= r_status[t];
		rsp_address <= r_addr[t];
		rsp_count <= r_count[t];
		for (int w = 0; w <= int'(r_count[t]); w++) begin
			rsp_valid <= 1'b1;
			rsp_data <= (w == 0) ? r_data[t] : r_extra[t][w-1];
			do @(negedge clk); while (!rsp_ready);
			@(posedge clk);
		end
		rsp_valid <= 1'b0;
	endtask

	initial begin
		int total;
		int stall;
		int base;
		int errs_before;
		rst = 1'b1;
		rx_line = 1'b1;
		req_ready = 1'b1;
		rsp_valid = 1'b0;
		rsp_status = '0;
		rsp_address = '0;
		rsp_data = '0;
		rsp_count = '0;

		set_request(0, "read", "", 28'h3, 32'h0000_0002, 32'h0000_1000,
			32'h1234_5678, 32'h0, 32'h0, 0);
		set_response(0, 32'h0000_00A5, 32'h0000_1000, 32'h89AB_CDEF, 28'h0, 32'h0, 32'h0);
		set_request(1, "write x3 stalled", "", 28'h2, 32'h00C0_0001, 32'hFFFF_0040,
			32'hDEAD_BEEF, 32'hCAFE_F00D, 32'h0123_4567, 500);
		set_response(1, 32'h0000_0000, 32'hFFFF_0040, 32'h1111_2222, 28'h2,
			32'h3333_4444, 32'h5A5A_C3C3);
		// junk and a frame killed by G in its address before a good read
		set_request(2, "abort and resync", "q#L0000000000000051234G6789z", 28'h1,
			32'h0000_0005, 32'hABCD_EF01, 32'h1122_3344, 32'h0, 32'h0, 0);
		set_response(2, 32'h8000_0001, 32'hABCD_EF01, 32'h1122_3344, 28'h1,
			32'h0F1E_2D3C, 32'h0);
		set_request(3, "write x1 stalled", "", 28'h0, 32'h0007_0001, 32'h0000_0008,
			32'h7654_3210, 32'h0, 32'h0, 300);
		set_response(3, 32'hFFFF_FFFF, 32'h0000_0008, 32'h0000_0000, 28'h0, 32'h0, 32'h0);

		// limit is twice the serial time of every character in the table
		total = 0;
		for (int t = 0; t < NUM_TESTS; t++) begin
			build_frame(t);
			build_response(t);
			total = total + send_q.size() + exp_chars.size();
		end
		cycle_limit = 2 * total * 10 * BIT_CLKS;

		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);

		for (int t = 0; t < NUM_TESTS; t++) begin
			errs_before = errors;
			base = transfers;
			build_frame(t);
			build_response(t);
			got_chars.delete();
			stall = (t_stall_max[t] > 0) ? 1 + ({$random(seed)} % t_stall_max[t]) : 0;
			if (stall > 0) begin
				req_ready <= 1'b0;
			end
			fork
				drive_frame();
				take_words(t, stall);
			join
			// let the last byte clear the receiver before counting words
			repeat (2 * BIT_CLKS) @(posedge clk);
			check_value("req_transfers", 32'(exp_data.size()), 32'(transfers - base));

			send_response(t);
			while (got_chars.size() < exp_chars.size()) begin
				@(negedge clk);
			end
			// longer than one more character so a surplus one gets counted
			repeat (12 * BIT_CLKS) @(negedge clk);
			check_value("tx_char_count", 32'(exp_chars.size()), 32'(got_chars.size()));
			if (got_chars.size() == exp_chars.size()) begin
				for (int i = 0; i < exp_chars.size(); i++) begin
					check_value("tx_char", {24'h0, exp_chars[i]}, {24'h0, got_chars[i]});
				end
			end
			@(posedge clk);
			$display("test %0d %s: %0d words, stall %0d, %0d chars, %0d errors", t, t_name[t],
				exp_data.size(), stall, got_chars.size(), errors - errs_before);
		end

		check_value("tx_stop_errors", 32'd0, 32'(stop_errors));
		$display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
			NUM_TESTS, checks, errors, uut.u_checker.failures);
		if (errors == 0 && uut.u_checker.failures == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

//--- verilog.f
hw/host_link_pkg.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/hex_request_parser.sv
hw/hex_response_writer.sv
hw/uart_host_port.sv
bench/uart_host_port_checker.sv
bench/uart_host_port_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = uart_host_port_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
